//--- verilog/ms_defines.svh
`ifndef MS_DEFINES_SVH
`define MS_DEFINES_SVH

// ----------------------------------------------------------
// Widths, depths and counts
// ----------------------------------------------------------
`define MS_DATA_W        32  // Signed sample width
`define MS_BLOCK_DEPTH   64
`define MS_ADDR_W        6   // Covers MS_BLOCK_DEPTH
`define MS_SELECT_COUNT  10  // Index strobes per block
`define MS_BLOCK_COUNT   4
`define MS_RESULT_COUNT  8   // Two per block

`endif

//--- verilog/ms_pkg.sv
`default_nettype none

`include "ms_defines.svh"

package ms_pkg;

	typedef logic signed [`MS_DATA_W-1:0] sample_t;  // One sample
	typedef logic [`MS_ADDR_W-1:0] addr_t;           // Buffer address or index

	// Merge sorter phases
	typedef enum logic [1:0] {
		st_collect,
		st_merge_pairs,
		st_merge_quads
	} merge_state_t;

endpackage

`default_nettype wire

//--- verilog/sample_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ms_defines.svh"

module sample_buffer
(
	input  wire              clk,
	input  wire              rst_n,
	input  wire              data_valid,
	input  wire ms_pkg::sample_t data,
	input  wire              number_valid,
	input  wire ms_pkg::addr_t number,
	output logic             rd_valid,
	output ms_pkg::sample_t  rd_data
);

	ms_pkg::sample_t mem [0:`MS_BLOCK_DEPTH-1];  // Behavioral block store
	ms_pkg::addr_t   wr_addr;

	// Write address, restarts for every block
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			wr_addr <= '0;
		else if (data_valid)
		begin
			if (wr_addr == ms_pkg::addr_t'(`MS_BLOCK_DEPTH - 1))
				wr_addr <= '0;
			else
				wr_addr <= wr_addr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (data_valid)
			mem[wr_addr] <= data;
		if (number_valid)
			rd_data <= mem[number];  // Registered read
	end

	// Read result lands one cycle after the index strobe
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= number_valid;
	end

endmodule

`default_nettype wire

//--- verilog/top_two_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ms_defines.svh"

module top_two_tracker
(
	input  wire              clk,
	input  wire              rst_n,
	input  wire              rd_valid,
	input  wire ms_pkg::sample_t rd_data,
	output logic             pair_valid,
	output ms_pkg::sample_t  pair_first,
	output ms_pkg::sample_t  pair_second
);

	localparam int SEL_W = $clog2(`MS_SELECT_COUNT);
	localparam ms_pkg::sample_t SAMPLE_MIN = {1'b1, {(`MS_DATA_W - 1){1'b0}}};

	logic [SEL_W-1:0] sel_cnt;  // Selected samples seen in this block
	logic             first_sel;
	logic             last_sel;
	ms_pkg::sample_t  run_first;
	ms_pkg::sample_t  run_second;
	ms_pkg::sample_t  next_first;
	ms_pkg::sample_t  next_second;

	assign first_sel = (sel_cnt == '0);
	assign last_sel  = (sel_cnt == SEL_W'(`MS_SELECT_COUNT - 1));

	// ----------------------------------------------------------
	// Top-two update, signed compare
	// ----------------------------------------------------------
	always_comb
	begin
		next_first  = run_first;
		next_second = run_second;
		if (first_sel)
		begin
			next_first  = rd_data;
			next_second = SAMPLE_MIN;  // Nothing ranks below this
		end
		else if (rd_data > run_first)
		begin
			next_first  = rd_data;
			next_second = run_first;  // Old max drops to second
		end
		else if (rd_data > run_second)
			next_second = rd_data;  // Ties with max land here
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sel_cnt    <= '0;
			run_first  <= SAMPLE_MIN;
			run_second <= SAMPLE_MIN;
			pair_valid <= 1'b0;
		end
		else
		begin
			pair_valid <= rd_valid && last_sel;
			if (rd_valid)
			begin
				if (last_sel)
				begin
					// Block done, start clean
					sel_cnt    <= '0;
					run_first  <= SAMPLE_MIN;
					run_second <= SAMPLE_MIN;
				end
				else
				begin
					sel_cnt    <= sel_cnt + 1'b1;
					run_first  <= next_first;
					run_second <= next_second;
				end
			end
		end
	end

	// Final pair of the block
	always_ff @(posedge clk)
	begin
		if (rd_valid && last_sel)
		begin
			pair_first  <= next_first;
			pair_second <= next_second;
		end
	end

endmodule

`default_nettype wire

//--- verilog/merge_sorter.sv
`timescale 1ns/1ps
`default_nettype none

`include "ms_defines.svh"

module merge_sorter
(
	input  wire              clk,
	input  wire              rst_n,
	input  wire              pair_valid,
	input  wire ms_pkg::sample_t pair_first,
	input  wire ms_pkg::sample_t pair_second,
	output logic             out_valid,
	output ms_pkg::sample_t  out_data
);

	localparam int PAIR_W = $clog2(`MS_BLOCK_COUNT);
	localparam int STEP_W = $clog2(`MS_RESULT_COUNT);

	ms_pkg::merge_state_t state;
	logic [PAIR_W-1:0]    pair_cnt;
	logic [STEP_W-1:0]    step;

	ms_pkg::sample_t pair_list [0:`MS_BLOCK_COUNT-1][0:1];  // Sorted pairs per block
	ms_pkg::sample_t quad_a [0:3];  // Blocks 0 and 1 merged
	ms_pkg::sample_t quad_b [0:3];  // Blocks 2 and 3 merged

	// Read pointers, top bit set once the list is used up
	logic [1:0] ptr_a0;
	logic [1:0] ptr_a1;
	logic [1:0] ptr_b0;
	logic [1:0] ptr_b1;
	logic [2:0] ptr_qa;
	logic [2:0] ptr_qb;

	ms_pkg::sample_t head_a0;
	ms_pkg::sample_t head_a1;
	ms_pkg::sample_t head_b0;
	ms_pkg::sample_t head_b1;
	ms_pkg::sample_t head_qa;
	ms_pkg::sample_t head_qb;
	logic            take_a;
	logic            take_b;
	logic            take_q;

	// Left list wins ties, an exhausted list yields
	function automatic logic take_left(input ms_pkg::sample_t left,
		input ms_pkg::sample_t right, input logic left_done, input logic right_done);
		return !left_done && (right_done || left >= right);
	endfunction

	assign head_a0 = pair_list[0][ptr_a0[0]];
	assign head_a1 = pair_list[1][ptr_a1[0]];
	assign head_b0 = pair_list[2][ptr_b0[0]];
	assign head_b1 = pair_list[3][ptr_b1[0]];
	assign head_qa = quad_a[ptr_qa[1:0]];
	assign head_qb = quad_b[ptr_qb[1:0]];

	assign take_a = take_left(head_a0, head_a1, ptr_a0[1], ptr_a1[1]);
	assign take_b = take_left(head_b0, head_b1, ptr_b0[1], ptr_b1[1]);
	assign take_q = take_left(head_qa, head_qb, ptr_qa[2], ptr_qb[2]);

	// Final 4v4 merge drives the output directly
	assign out_valid = (state == ms_pkg::st_merge_quads);
	assign out_data  = take_q ? head_qa : head_qb;

	// ----------------------------------------------------------
	// Control FSM
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= ms_pkg::st_collect;
			pair_cnt <= '0;
			step     <= '0;
			ptr_a0   <= '0;
			ptr_a1   <= '0;
			ptr_b0   <= '0;
			ptr_b1   <= '0;
			ptr_qa   <= '0;
			ptr_qb   <= '0;
		end
		else
		begin
			case (state)
				ms_pkg::st_collect:
				begin
					step   <= '0;
					ptr_a0 <= '0;
					ptr_a1 <= '0;
					ptr_b0 <= '0;
					ptr_b1 <= '0;
					ptr_qa <= '0;
					ptr_qb <= '0;
					if (pair_valid)
					begin
						pair_cnt <= pair_cnt + 1'b1;
						if (pair_cnt == PAIR_W'(`MS_BLOCK_COUNT - 1))
						begin
							pair_cnt <= '0;
							state    <= ms_pkg::st_merge_pairs;
						end
					end
				end
				ms_pkg::st_merge_pairs:  // Two 2v2 merges side by side
				begin
					if (take_a)
						ptr_a0 <= ptr_a0 + 1'b1;
					else
						ptr_a1 <= ptr_a1 + 1'b1;
					if (take_b)
						ptr_b0 <= ptr_b0 + 1'b1;
					else
						ptr_b1 <= ptr_b1 + 1'b1;
					step <= step + 1'b1;
					if (step == STEP_W'(3))
					begin
						step  <= '0;
						state <= ms_pkg::st_merge_quads;
					end
				end
				ms_pkg::st_merge_quads:
				begin
					if (take_q)
						ptr_qa <= ptr_qa + 1'b1;
					else
						ptr_qb <= ptr_qb + 1'b1;
					step <= step + 1'b1;
					if (step == STEP_W'(`MS_RESULT_COUNT - 1))
					begin
						step  <= '0;
						state <= ms_pkg::st_collect;
					end
				end
				default:
					state <= ms_pkg::st_collect;
			endcase
		end
	end

	// Pair store and intermediate lists
	always_ff @(posedge clk)
	begin
		if (state == ms_pkg::st_collect && pair_valid)
		begin
			pair_list[pair_cnt][0] <= pair_first;
			pair_list[pair_cnt][1] <= pair_second;
		end
		if (state == ms_pkg::st_merge_pairs)
		begin
			quad_a[step[1:0]] <= take_a ? head_a0 : head_a1;
			quad_b[step[1:0]] <= take_b ? head_b0 : head_b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/ms_top.sv
`timescale 1ns/1ps
`default_nettype none

module ms_top
(
	input  wire              clk,
	input  wire              rst_n,
	input  wire              data_valid,
	input  wire ms_pkg::sample_t data,
	input  wire              number_valid,
	input  wire ms_pkg::addr_t number,
	output logic             out_valid,
	output ms_pkg::sample_t  out_data
);

	// Buffer to tracker
	logic            rd_valid;
	ms_pkg::sample_t rd_data;

	// Tracker to sorter
	logic            pair_valid;
	ms_pkg::sample_t pair_first;
	ms_pkg::sample_t pair_second;

	sample_buffer u_sample_buffer
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.data_valid   (data_valid),
		.data         (data),
		.number_valid (number_valid),
		.number       (number),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data)
	);

	top_two_tracker u_top_two_tracker
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data),
		.pair_valid  (pair_valid),
		.pair_first  (pair_first),
		.pair_second (pair_second)
	);

	merge_sorter u_merge_sorter
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.pair_valid  (pair_valid),
		.pair_first  (pair_first),
		.pair_second (pair_second),
		.out_valid   (out_valid),
		.out_data    (out_data)
	);

endmodule

`default_nettype wire

//--- testbench/ms_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "ms_defines.svh"

module ms_assertions
(
	input wire                  clk,
	input wire                  rst_n,
	input wire                  out_valid,
	input wire ms_pkg::sample_t out_data
);

	int              fail_count = 0;
	logic [3:0]      run_len;  // High cycles in the current run
	logic            prev_valid;
	ms_pkg::sample_t prev_data;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run_len    <= '0;
			prev_valid <= 1'b0;
			prev_data  <= '0;
		end
		else
		begin
			run_len    <= out_valid ? run_len + 1'b1 : '0;
			prev_valid <= out_valid;
			prev_data  <= out_data;
		end
	end

	// ----------------------------------------------------------
	// Output stream checks
	// ----------------------------------------------------------
	run_length: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid ? (run_len < 4'(`MS_RESULT_COUNT))
			: (run_len == '0 || run_len == 4'(`MS_RESULT_COUNT)))
	else
	begin
		$error("out_valid run length differs from the result count");
		fail_count++;
	end

	descending: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && prev_valid) |-> (out_data <= prev_data))  // Signed compare
	else
	begin
		$error("out_data increased within a run");
		fail_count++;
	end

	valid_known: assert property (@(posedge clk) !$isunknown(out_valid))
	else
	begin
		$error("out_valid is unknown");
		fail_count++;
	end

endmodule

bind ms_top ms_assertions u_ms_assertions
(
	.clk       (clk),
	.rst_n     (rst_n),
	.out_valid (out_valid),
	.out_data  (out_data)
);

`default_nettype wire

//--- testbench/tb_ms_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ms_defines.svh"

module tb_ms_top;

	localparam int CYCLE_LIMIT = 2500;  // Five jobs of roughly 350 cycles each

	logic            clk;
	logic            rst_n;
	logic            data_valid;
	ms_pkg::sample_t data;
	logic            number_valid;
	ms_pkg::addr_t   number;
	logic            out_valid;
	ms_pkg::sample_t out_data;

	ms_pkg::sample_t block_mem [0:`MS_BLOCK_DEPTH-1];  // Model copy of the buffer
	ms_pkg::sample_t job_vals [0:`MS_RESULT_COUNT-1];
	ms_pkg::sample_t exp_q [$];
	string           name_q [$];  // Job name per expected result
	int              compare_errors;
	int              cycle_count;

	ms_top u_ms_top
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.data_valid   (data_valid),
		.data         (data),
		.number_valid (number_valid),
		.number       (number),
		.out_valid    (out_valid),
		.out_data     (out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------------------------
	// Drivers, all on the falling edge
	// ----------------------------------------------------------
	task automatic drive_idle();
		@(negedge clk);
		data_valid   = 1'b0;
		number_valid = 1'b0;
	endtask

	task automatic drive_data(input ms_pkg::sample_t value);
		@(negedge clk);
		data_valid   = 1'b1;
		data         = value;
		number_valid = 1'b0;
	endtask

	task automatic drive_number(input ms_pkg::addr_t index);
		@(negedge clk);
		data_valid   = 1'b0;
		number_valid = 1'b1;
		number       = index;
	endtask

	// Hold off until the previous job has streamed out
	task automatic wait_drained();
		while (exp_q.size() != 0 || out_valid)
			drive_idle();
	endtask

	task automatic sort_job_vals();
		ms_pkg::sample_t key;
		int              j;
		for (int i = 1; i < `MS_RESULT_COUNT; i++)
		begin
			key = job_vals[i];
			j   = i - 1;
			while (j >= 0 && job_vals[j] < key)
			begin
				job_vals[j + 1] = job_vals[j];
				j--;
			end
			job_vals[j + 1] = key;
		end
	endtask

	// Mode 0 random, 1 one repeated index in block 1, 2 all negative samples
	task automatic run_job(input string name, input int mode);
		ms_pkg::sample_t value;
		ms_pkg::sample_t sel [0:`MS_SELECT_COUNT-1];
		ms_pkg::addr_t   index;
		ms_pkg::addr_t   dup_index;
		int              top_idx;
		int              second_idx;
		for (int b = 0; b < `MS_BLOCK_COUNT; b++)
		begin
			for (int i = 0; i < `MS_BLOCK_DEPTH; i++)
			begin
				if (mode == 2 && i == 0)
					value = -1;
				else if (mode == 2 && i == 1)
					value = -100;
				else if (mode == 2)
					value = ms_pkg::sample_t'(-1 - int'($urandom % 5000));
				else
					value = ms_pkg::sample_t'($urandom);
				block_mem[i] = value;
				if ($urandom % 8 == 0)
					drive_idle();  // Random gap
				drive_data(value);
			end
			drive_idle();
			if (b == 0)
				wait_drained();
			dup_index = ms_pkg::addr_t'($urandom);
			for (int k = 0; k < `MS_SELECT_COUNT; k++)
			begin
				if (mode == 1 && b == 1)
					index = dup_index;
				else if (mode == 2 && k < 2)
					index = ms_pkg::addr_t'(k);  // Pick -1 and -100
				else
					index = ms_pkg::addr_t'($urandom);
				sel[k] = block_mem[index];
				if ($urandom % 8 == 0)
					drive_idle();
				drive_number(index);
			end
			drive_idle();
			// Largest, then largest of the rest with one copy of it removed
			top_idx = 0;
			for (int k = 1; k < `MS_SELECT_COUNT; k++)
				if (sel[k] > sel[top_idx])
					top_idx = k;
			second_idx = (top_idx == 0) ? 1 : 0;
			for (int k = 0; k < `MS_SELECT_COUNT; k++)
				if (k != top_idx && sel[k] > sel[second_idx])
					second_idx = k;
			job_vals[2 * b]     = sel[top_idx];
			job_vals[2 * b + 1] = sel[second_idx];
		end
		sort_job_vals();
		for (int i = 0; i < `MS_RESULT_COUNT; i++)
		begin
			exp_q.push_back(job_vals[i]);
			name_q.push_back(name);
		end
	endtask

	task automatic compare_result(input string name, input ms_pkg::sample_t expected,
		input ms_pkg::sample_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
			compare_errors++;
		end
	endtask

	// Result monitor
	always @(posedge clk)
	begin
		if (rst_n && out_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Result streamed while no job was pending");
				compare_errors++;
			end
			else
				compare_result(name_q.pop_front(), exp_q.pop_front(), out_data);
		end
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hc55c5fd2));
		compare_errors = 0;
		rst_n          = 1'b0;
		data_valid     = 1'b0;
		data           = '0;
		number_valid   = 1'b0;
		number         = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (10) drive_idle();  // Quiet window before the first job
		run_job("random_job", 0);
		run_job("duplicate_index", 1);
		run_job("negative_samples", 2);
		run_job("back_to_back_a", 0);
		run_job("back_to_back_b", 0);
		wait_drained();
		repeat (4) drive_idle();
		$display("Errors: %0d compare, %0d assertion", compare_errors,
			u_ms_top.u_ms_assertions.fail_count);
		if (compare_errors == 0 && u_ms_top.u_ms_assertions.fail_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/ms_pkg.sv
verilog/sample_buffer.sv
verilog/top_two_tracker.sv
verilog/merge_sorter.sv
verilog/ms_top.sv
testbench/ms_assertions.sv
testbench/tb_ms_top.sv

//--- Makefile
TOP := tb_ms_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)

run: build
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only -Wall -Iverilog verilog/ms_pkg.sv verilog/sample_buffer.sv \
		verilog/top_two_tracker.sv verilog/merge_sorter.sv verilog/ms_top.sv \
		--top-module ms_top

clean:
	rm -rf obj_dir
